// File: tb.f
+incdir+.
fifo_pkg.sv
fifo_level_tracker.sv
ram_bank_2p.sv
ram_2p_asym.sv
asym_fifo_sync.sv
fifo_subsys_top.sv
tb_fifo_sva.sv
tb_fifo_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fifo_subsys -f tb.f -o sim_fifo

./obj_dir/sim_fifo 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without finishing the tests"
    exit 1
fi
exit 0

// File: tb_fifo_subsys.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module tb_fifo_subsys;

    localparam int PERIOD = 8;
    localparam int CAP    = 2 ** `FIFO_ADDR_W;
    // bytes per read word
    localparam int RATIO  = `FIFO_R_DATA_W / `FIFO_W_DATA_W;
    localparam int BYTE_W = `FIFO_W_DATA_W;

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_WRITE,
        OP_READ,
        OP_WR_RD,
        OP_CLEAR
    } op_t;

    typedef struct packed {
        op_t               op;
        logic [15:0]       count;
        logic              use_lfsr;
        fifo_pkg::w_word_t value;
    } row_t;

    logic              clk = 1'b0;
    logic              arst;
    logic              clr;
    logic              w_en;
    fifo_pkg::w_word_t w_data;
    logic              r_en;
    fifo_pkg::r_word_t r_data;
    logic              w_full;
    logic              r_empty;
    fifo_pkg::level_t  level;

    row_t              rows [$];
    fifo_pkg::w_word_t model_q [$];
    logic [31:0]       lfsr;
    logic              rd_pending;
    fifo_pkg::r_word_t rd_expect;
    logic              table_ready = 1'b0;

    fifo_subsys_top u_dut (
        .clk     (clk),
        .arst    (arst),
        .clr     (clr),
        .w_en    (w_en),
        .w_data  (w_data),
        .r_en    (r_en),
        .r_data  (r_data),
        .w_full  (w_full),
        .r_empty (r_empty),
        .level   (level)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_lfsr_byte(output fifo_pkg::w_word_t b);
        b = '0;
        for (int i = 0; i < BYTE_W; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[BYTE_W-2:0], lfsr[0]};
        end
    endtask

    function automatic void add_row(input op_t op, input int count, input logic use_lfsr,
                                    input fifo_pkg::w_word_t value);
        row_t r;
        r.op       = op;
        r.count    = 16'(count);
        r.use_lfsr = use_lfsr;
        r.value    = value;
        rows.push_back(r);
    endfunction

    task automatic build_table();
        // reads on an empty FIFO are refused
        add_row(OP_READ, 2, 1'b0, 8'h00);
        // writes past capacity are dropped
        add_row(OP_WRITE, CAP + 4, 1'b1, 8'h00);
        add_row(OP_WR_RD, 2, 1'b1, 8'h00);
        add_row(OP_READ, CAP / RATIO + 2, 1'b0, 8'h00);
        // partial word stays unreadable
        add_row(OP_WRITE, 1, 1'b0, 8'h11);
        add_row(OP_WRITE, 1, 1'b0, 8'h22);
        add_row(OP_READ, 3, 1'b0, 8'h00);
        add_row(OP_WRITE, 1, 1'b0, 8'h33);
        add_row(OP_READ, 1, 1'b0, 8'h00);
        // streaming traffic wraps the pointers several times
        add_row(OP_WRITE, 20, 1'b1, 8'h00);
        add_row(OP_WR_RD, 48, 1'b1, 8'h00);
        add_row(OP_READ, 20, 1'b0, 8'h00);
        add_row(OP_IDLE, 2, 1'b0, 8'h00);
        // clear a full FIFO and reuse it
        add_row(OP_WRITE, CAP, 1'b1, 8'h00);
        add_row(OP_CLEAR, 1, 1'b0, 8'h00);
        add_row(OP_IDLE, 1, 1'b0, 8'h00);
        add_row(OP_WRITE, 9, 1'b1, 8'h00);
        add_row(OP_READ, 3, 1'b0, 8'h00);
        add_row(OP_IDLE, 1, 1'b0, 8'h00);
    endtask

    // state seen here reflects the strobes of the previous cycle
    task automatic compare_outputs();
        check_value("level", 32'(level), 32'(model_q.size()));
        check_value("w_full", 32'(w_full), 32'(model_q.size() == CAP));
        check_value("r_empty", 32'(r_empty), 32'(model_q.size() < RATIO));
        if (rd_pending) begin
            check_value("r_data", r_data, rd_expect);
            rd_pending = 1'b0;
        end
    endtask

    task automatic run_cycle(input op_t op, input logic use_lfsr, input fifo_pkg::w_word_t value);
        fifo_pkg::w_word_t b;
        fifo_pkg::r_word_t word;
        logic              do_w;
        logic              do_r;
        logic              w_ok;
        logic              r_ok;
        do_w = (op == OP_WRITE) || (op == OP_WR_RD);
        do_r = (op == OP_READ) || (op == OP_WR_RD);
        b = value;
        if (do_w && use_lfsr) begin
            take_lfsr_byte(b);
        end
        w_ok = do_w && (model_q.size() < CAP);
        r_ok = do_r && (model_q.size() >= RATIO);
        @(posedge clk);
        w_en   <= do_w;
        r_en   <= do_r;
        clr    <= (op == OP_CLEAR);
        w_data <= b;
        @(negedge clk);
        compare_outputs();
        if (op == OP_CLEAR) begin
            model_q.delete();
        end else begin
            // first byte popped lands in the low lane
            if (r_ok) begin
                word = '0;
                for (int i = 0; i < RATIO; i++) begin
                    word[i*BYTE_W +: BYTE_W] = model_q.pop_front();
                end
                rd_expect  = word;
                rd_pending = 1'b1;
            end
            if (w_ok) begin
                model_q.push_back(b);
            end
        end
    endtask

    initial begin
        arst       = 1'b1;
        clr        = 1'b0;
        w_en       = 1'b0;
        r_en       = 1'b0;
        w_data     = '0;
        lfsr       = 32'h94c29ae4;
        rd_pending = 1'b0;
        rd_expect  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        arst <= 1'b0;
        @(negedge clk);
        compare_outputs();
        foreach (rows[i]) begin
            for (int n = 0; n < int'(rows[i].count); n++) begin
                run_cycle(rows[i].op, rows[i].use_lfsr, rows[i].value);
            end
        end
        // last strobes and read data still need a look
        run_cycle(OP_IDLE, 1'b0, 8'h00);
        run_cycle(OP_IDLE, 1'b0, 8'h00);
        $display("Test completed successfully");
        $finish;
    end

    // limit follows the table length plus reset and flush margin
    initial begin
        int total;
        total = 0;
        wait (table_ready);
        foreach (rows[i]) begin
            total += int'(rows[i].count);
        end
        #((total + 3 + 2 + 50) * PERIOD);
        $display("watchdog: simulation ran out of time after %0t", $time);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: tb_fifo_sva.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module tb_fifo_sva (
    input logic             clk,
    input logic             arst,
    input logic             w_full,
    input logic             r_empty,
    input fifo_pkg::level_t level
);

    localparam int CAP   = 2 ** `FIFO_ADDR_W;
    localparam int RATIO = `FIFO_R_DATA_W / `FIFO_W_DATA_W;

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (arst) !(w_full && r_empty)
    ) else $error("w_full and r_empty asserted together");

    a_level_max: assert property (
        @(posedge clk) disable iff (arst) level <= CAP
    ) else $error("level 0x%0h above capacity", level);

    // empty means less than one read word stored
    a_empty_level: assert property (
        @(posedge clk) disable iff (arst) r_empty == (level < RATIO)
    ) else $error("r_empty %0b disagrees with level 0x%0h", r_empty, level);

endmodule

bind fifo_subsys_top tb_fifo_sva u_sva (
    .clk     (clk),
    .arst    (arst),
    .w_full  (w_full),
    .r_empty (r_empty),
    .level   (level)
);

// File: fifo_subsys_top.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fifo_subsys_top (
    input  logic               clk,
    input  logic               arst,
    input  logic               clr,
    input  logic               w_en,
    input  fifo_pkg::w_word_t  w_data,
    input  logic               r_en,
    output fifo_pkg::r_word_t  r_data,
    output logic               w_full,
    output logic               r_empty,
    output fifo_pkg::level_t   level
);

    localparam int N      = fifo_pkg::N_BANKS;
    localparam int DATA_W = $bits(fifo_pkg::bank_data_t);
    localparam int ADDR_W = $bits(fifo_pkg::bank_addr_t);

    // flat external memory bus, slice k belongs to bank k
    logic [N-1:0]        ext_mem_w_en;
    logic [N*DATA_W-1:0] ext_mem_w_data;
    logic [N*ADDR_W-1:0] ext_mem_w_addr;
    logic                ext_mem_r_en;
    logic [N*ADDR_W-1:0] ext_mem_r_addr;
    logic [N*DATA_W-1:0] ext_mem_r_data;

    asym_fifo_sync #(
        .W_DATA_W (`FIFO_W_DATA_W),
        .R_DATA_W (`FIFO_R_DATA_W),
        .ADDR_W   (`FIFO_ADDR_W)
    ) u_fifo (
        .clk            (clk),
        .arst           (arst),
        .clr            (clr),
        .w_en           (w_en),
        .w_data         (w_data),
        .w_full         (w_full),
        .r_en           (r_en),
        .r_data         (r_data),
        .r_empty        (r_empty),
        .level          (level),
        .ext_mem_w_en   (ext_mem_w_en),
        .ext_mem_w_data (ext_mem_w_data),
        .ext_mem_w_addr (ext_mem_w_addr),
        .ext_mem_r_en   (ext_mem_r_en),
        .ext_mem_r_addr (ext_mem_r_addr),
        .ext_mem_r_data (ext_mem_r_data)
    );

    for (genvar k = 0; k < N; k++) begin : g_bank
        ram_bank_2p u_bank (
            .clk    (clk),
            .w_en   (ext_mem_w_en[k]),
            .w_addr (ext_mem_w_addr[k*ADDR_W +: ADDR_W]),
            .w_data (ext_mem_w_data[k*DATA_W +: DATA_W]),
            .r_en   (ext_mem_r_en),
            .r_addr (ext_mem_r_addr[k*ADDR_W +: ADDR_W]),
            .r_data (ext_mem_r_data[k*DATA_W +: DATA_W])
        );
    end

endmodule

// File: asym_fifo_sync.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module asym_fifo_sync #(
    parameter int W_DATA_W = `FIFO_W_DATA_W,
    parameter int R_DATA_W = `FIFO_R_DATA_W,
    parameter int ADDR_W   = `FIFO_ADDR_W,
    localparam int MAX_DATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
    localparam int MIN_DATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W,
    localparam int N          = MAX_DATA_W / MIN_DATA_W,
    localparam int MIN_ADDR_W = ADDR_W - $clog2(N),
    localparam int W_ADDR_W   = (W_DATA_W == MAX_DATA_W) ? MIN_ADDR_W : ADDR_W,
    localparam int R_ADDR_W   = (R_DATA_W == MAX_DATA_W) ? MIN_ADDR_W : ADDR_W
) (
    input  logic                     clk,
    input  logic                     arst,
    input  logic                     clr,
    input  logic                     w_en,
    input  logic [W_DATA_W-1:0]      w_data,
    output logic                     w_full,
    input  logic                     r_en,
    output logic [R_DATA_W-1:0]      r_data,
    output logic                     r_empty,
    output fifo_pkg::level_t         level,
    output logic [N-1:0]             ext_mem_w_en,
    output logic [MIN_DATA_W*N-1:0]  ext_mem_w_data,
    output logic [MIN_ADDR_W*N-1:0]  ext_mem_w_addr,
    output logic                     ext_mem_r_en,
    output logic [MIN_ADDR_W*N-1:0]  ext_mem_r_addr,
    input  logic [MIN_DATA_W*N-1:0]  ext_mem_r_data
);

    logic                w_en_eff;
    logic                r_en_eff;
    logic [W_ADDR_W-1:0] w_ptr;
    logic [R_ADDR_W-1:0] r_ptr;

    // strobes against a full or empty FIFO are dropped here
    assign w_en_eff = w_en && !w_full;
    assign r_en_eff = r_en && !r_empty;

    // write pointer in write word units
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            w_ptr <= '0;
        end else if (clr) begin
            w_ptr <= '0;
        end else if (w_en_eff) begin
            w_ptr <= w_ptr + W_ADDR_W'(1);
        end
    end

    // read pointer in read word units
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            r_ptr <= '0;
        end else if (clr) begin
            r_ptr <= '0;
        end else if (r_en_eff) begin
            r_ptr <= r_ptr + R_ADDR_W'(1);
        end
    end

    fifo_level_tracker #(
        .W_DATA_W (W_DATA_W),
        .R_DATA_W (R_DATA_W),
        .ADDR_W   (ADDR_W)
    ) u_level (
        .clk      (clk),
        .arst     (arst),
        .clr      (clr),
        .w_acc    (w_en_eff),
        .r_acc    (r_en_eff),
        .level    (level),
        .w_full   (w_full),
        .r_empty  (r_empty)
    );

    // steers pointers and data onto the external banks
    ram_2p_asym #(
        .W_DATA_W (W_DATA_W),
        .R_DATA_W (R_DATA_W),
        .ADDR_W   (ADDR_W)
    ) u_ram (
        .clk            (clk),
        .w_en           (w_en_eff),
        .w_data         (w_data),
        .w_addr         (w_ptr),
        .r_en           (r_en_eff),
        .r_addr         (r_ptr),
        .r_data         (r_data),
        .ext_mem_w_en   (ext_mem_w_en),
        .ext_mem_w_data (ext_mem_w_data),
        .ext_mem_w_addr (ext_mem_w_addr),
        .ext_mem_r_en   (ext_mem_r_en),
        .ext_mem_r_addr (ext_mem_r_addr),
        .ext_mem_r_data (ext_mem_r_data)
    );

endmodule

// File: ram_2p_asym.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module ram_2p_asym #(
    parameter int W_DATA_W = `FIFO_W_DATA_W,
    parameter int R_DATA_W = `FIFO_R_DATA_W,
    parameter int ADDR_W   = `FIFO_ADDR_W,
    localparam int MAX_DATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
    localparam int MIN_DATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W,
    localparam int N          = MAX_DATA_W / MIN_DATA_W,
    localparam int SEL_W      = $clog2(N),
    localparam int MIN_ADDR_W = ADDR_W - SEL_W,
    localparam int W_ADDR_W   = (W_DATA_W == MAX_DATA_W) ? MIN_ADDR_W : ADDR_W,
    localparam int R_ADDR_W   = (R_DATA_W == MAX_DATA_W) ? MIN_ADDR_W : ADDR_W
) (
    input  logic                        clk,
    input  logic                        w_en,
    input  logic [W_DATA_W-1:0]         w_data,
    input  logic [W_ADDR_W-1:0]         w_addr,
    input  logic                        r_en,
    input  logic [R_ADDR_W-1:0]         r_addr,
    output logic [R_DATA_W-1:0]         r_data,
    output logic [N-1:0]                ext_mem_w_en,
    output logic [MIN_DATA_W*N-1:0]     ext_mem_w_data,
    output logic [MIN_ADDR_W*N-1:0]     ext_mem_w_addr,
    output logic                        ext_mem_r_en,
    output logic [MIN_ADDR_W*N-1:0]     ext_mem_r_addr,
    input  logic [MIN_DATA_W*N-1:0]     ext_mem_r_data
);

    // all banks share one read strobe in every mode
    assign ext_mem_r_en = r_en;

    if (R_DATA_W > W_DATA_W) begin : g_narrow_w
        logic [SEL_W-1:0]      w_sel;
        logic [MIN_ADDR_W-1:0] w_bank_addr;

        // low pointer bits pick the byte lane, upper bits the row
        assign w_sel       = w_addr[SEL_W-1:0];
        assign w_bank_addr = w_addr[W_ADDR_W-1:SEL_W];

        for (genvar k = 0; k < N; k++) begin : g_bank
            assign ext_mem_w_en[k] = w_en && (w_sel == SEL_W'(k));
            assign ext_mem_w_data[k*MIN_DATA_W +: MIN_DATA_W] = w_data;
            assign ext_mem_w_addr[k*MIN_ADDR_W +: MIN_ADDR_W] = w_bank_addr;
            assign ext_mem_r_addr[k*MIN_ADDR_W +: MIN_ADDR_W] = r_addr;
        end

        // bank 0 holds the oldest byte, so lanes line up little-endian
        assign r_data = ext_mem_r_data;
    end else if (W_DATA_W > R_DATA_W) begin : g_narrow_r
        logic [SEL_W-1:0]      r_sel;
        logic [SEL_W-1:0]      r_sel_q;
        logic [MIN_ADDR_W-1:0] r_bank_addr;

        assign r_sel       = r_addr[SEL_W-1:0];
        assign r_bank_addr = r_addr[R_ADDR_W-1:SEL_W];

        // a wide write fills one row across every bank
        assign ext_mem_w_en   = {N{w_en}};
        assign ext_mem_w_data = w_data;

        for (genvar k = 0; k < N; k++) begin : g_bank
            assign ext_mem_w_addr[k*MIN_ADDR_W +: MIN_ADDR_W] = w_addr;
            assign ext_mem_r_addr[k*MIN_ADDR_W +: MIN_ADDR_W] = r_bank_addr;
        end

        // lane select follows the registered bank read by one cycle
        always_ff @(posedge clk) begin
            if (r_en) begin
                r_sel_q <= r_sel;
            end
        end

        assign r_data = ext_mem_r_data[r_sel_q*MIN_DATA_W +: MIN_DATA_W];
    end else begin : g_sym
        // equal widths, a single bank behind plain wiring
        assign ext_mem_w_en   = w_en;
        assign ext_mem_w_data = w_data;
        assign ext_mem_w_addr = w_addr;
        assign ext_mem_r_addr = r_addr;
        assign r_data         = ext_mem_r_data;
    end

endmodule

// File: ram_bank_2p.sv
`timescale 1ns/1ps

module ram_bank_2p (
    input  logic                  clk,
    input  logic                  w_en,
    input  fifo_pkg::bank_addr_t  w_addr,
    input  fifo_pkg::bank_data_t  w_data,
    input  logic                  r_en,
    input  fifo_pkg::bank_addr_t  r_addr,
    output fifo_pkg::bank_data_t  r_data
);

    localparam int DEPTH = 2 ** $bits(fifo_pkg::bank_addr_t);

    fifo_pkg::bank_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (w_en) begin
            mem[w_addr] <= w_data;
        end
    end

    // read data holds between read strobes
    always_ff @(posedge clk) begin
        if (r_en) begin
            r_data <= mem[r_addr];
        end
    end

endmodule

// File: fifo_level_tracker.sv
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fifo_level_tracker #(
    parameter int W_DATA_W = `FIFO_W_DATA_W,
    parameter int R_DATA_W = `FIFO_R_DATA_W,
    parameter int ADDR_W   = `FIFO_ADDR_W
) (
    input  logic              clk,
    input  logic              arst,
    input  logic              clr,
    input  logic              w_acc,
    input  logic              r_acc,
    output fifo_pkg::level_t  level,
    output logic              w_full,
    output logic              r_empty
);

    localparam int MAX_DATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
    localparam int MIN_DATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W;
    localparam int N          = MAX_DATA_W / MIN_DATA_W;

    // the wide side moves the level by N narrow units per access
    localparam fifo_pkg::level_t W_INCR = (W_DATA_W > R_DATA_W) ?
                                          fifo_pkg::level_t'(N) : fifo_pkg::level_t'(1);
    localparam fifo_pkg::level_t R_INCR = (R_DATA_W > W_DATA_W) ?
                                          fifo_pkg::level_t'(N) : fifo_pkg::level_t'(1);

    // capacity in narrow units
    localparam fifo_pkg::level_t FIFO_SIZE = fifo_pkg::level_t'(2 ** ADDR_W);

    fifo_pkg::level_t level_nxt;
    logic             w_full_nxt;
    logic             r_empty_nxt;

    // accepted accesses never push the level past the capacity or below 0
    always_comb begin
        level_nxt = level;
        if (w_acc) begin
            level_nxt = level_nxt + W_INCR;
        end
        if (r_acc) begin
            level_nxt = level_nxt - R_INCR;
        end
        if (clr) begin
            level_nxt = '0;
        end
    end

    // full once another wide write would not fit
    assign w_full_nxt  = level_nxt > (FIFO_SIZE - W_INCR);
    // empty while less than one read word is stored
    assign r_empty_nxt = level_nxt < R_INCR;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            level   <= '0;
            w_full  <= 1'b0;
            r_empty <= 1'b1;
        end else begin
            level   <= level_nxt;
            w_full  <= w_full_nxt;
            r_empty <= r_empty_nxt;
        end
    end

endmodule

// File: fifo_pkg.sv
`include "fifo_cfg.svh"

package fifo_pkg;

    // the wider and narrower of the two port widths
    localparam int MAX_DATA_W = (`FIFO_W_DATA_W > `FIFO_R_DATA_W) ?
                                `FIFO_W_DATA_W : `FIFO_R_DATA_W;
    localparam int MIN_DATA_W = (`FIFO_W_DATA_W < `FIFO_R_DATA_W) ?
                                `FIFO_W_DATA_W : `FIFO_R_DATA_W;

    // number of narrow banks making up one wide word
    localparam int N_BANKS     = MAX_DATA_W / MIN_DATA_W;
    localparam int BANK_ADDR_W = `FIFO_ADDR_W - $clog2(N_BANKS);

    typedef logic [`FIFO_W_DATA_W-1:0] w_word_t;
    typedef logic [`FIFO_R_DATA_W-1:0] r_word_t;

    // fill level in narrow units, one extra bit to hold the full count
    typedef logic [`FIFO_ADDR_W:0] level_t;

    typedef logic [MIN_DATA_W-1:0]  bank_data_t;
    typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

// File: fifo_cfg.svh
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// write side word width in bits
// the producer pushes one of these per accepted w_en
`define FIFO_W_DATA_W 8

// read side word width in bits
// one of these comes back per accepted r_en
`define FIFO_R_DATA_W 32

// address width in units of the narrower word
// capacity is 2**FIFO_ADDR_W narrow words, 64 bytes by default
`define FIFO_ADDR_W 6

// the two widths must divide evenly
// the larger over the smaller gives the bank count

`endif
